/* src.f */
+incdir+hw
hw/lsu_pkg.sv
hw/stage_if.sv
hw/mem_issue.sv
hw/stage_fifo.sv
hw/mem_access.sv
hw/data_ram.sv
hw/lsu_top.sv
sim/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Compile the LSU testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f src.f --top-module lsu_tb -Mdir obj_dir \
    || { echo "Verilator build did not complete"; exit 1; }

out=$(./obj_dir/Vlsu_tb)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && exit 0 || exit 1

/* sim/lsu_patterns.txt */
# op addr wdata rd exp_data exp_we exp_excp, all in hex
# op codes: 0 LD_B, 1 LD_BU, 2 LD_H, 3 LD_HU, 4 LD_W, 5 ST_B, 6 ST_H, 7 ST_W, 8 LL, 9 SC
7 00000000 12345678 01 00000000 0 0
4 00000000 00000000 02 12345678 1 0
7 00000004 80f17fa5 03 00000000 0 0
0 00000004 00000000 04 ffffffa5 1 0
1 00000004 00000000 05 000000a5 1 0
0 00000005 00000000 06 0000007f 1 0
0 00000006 00000000 08 fffffff1 1 0
1 00000006 00000000 09 000000f1 1 0
0 00000007 00000000 0a ffffff80 1 0
1 00000007 00000000 0b 00000080 1 0
2 00000004 00000000 0c 00007fa5 1 0
2 00000006 00000000 0e ffff80f1 1 0
3 00000006 00000000 0f 000080f1 1 0
7 00000008 1234c3d2 10 00000000 0 0
2 00000008 00000000 11 ffffc3d2 1 0
3 00000008 00000000 12 0000c3d2 1 0
2 0000000a 00000000 13 00001234 1 0
7 00000010 00000000 14 00000000 0 0
5 00000011 deadbeab 15 00000000 0 0
5 00000013 000000cd 16 00000000 0 0
4 00000010 00000000 17 cd00ab00 1 0
6 00000012 ffff9876 18 00000000 0 0
6 00000010 00004321 19 00000000 0 0
4 00000010 00000000 1a 98764321 1 0
5 00000010 00000011 1b 00000000 0 0
4 00000010 00000000 1c 98764311 1 0
7 00000020 aaaa5555 1d 00000000 0 0
8 00000020 00000000 1e aaaa5555 1 0
9 00000020 0badcafe 1f 00000001 1 0
4 00000020 00000000 01 0badcafe 1 0
9 00000020 77777777 02 00000000 1 0
4 00000020 00000000 03 0badcafe 1 0
2 00000005 00000000 04 00000000 0 1
6 00000011 0000ffff 05 00000000 0 1
4 00000002 00000000 06 00000000 0 1
7 00000013 ffffffff 07 00000000 0 1
8 00000021 00000000 08 00000000 0 1
9 00000022 00000000 09 00000000 0 1
4 00000010 00000000 0a 98764311 1 0
4 00000000 00000000 0b 12345678 1 0
8 00000020 00000000 0c 0badcafe 1 0
9 00000021 00000005 0d 00000000 0 1
9 00000020 13572468 0e 00000001 1 0
4 00000020 00000000 0f 13572468 1 0

/* sim/lsu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int DRAIN_CYCLES   = 20;

    logic                 clk;
    logic                 arst_n;
    logic                 req_valid;
    logic                 req_ready;
    mem_op_e              req_op;
    logic [`LSU_XLEN-1:0] req_addr;
    logic [`LSU_XLEN-1:0] req_data;
    logic [4:0]           req_rd;
    logic                 wb_valid;
    logic                 wb_ready;
    logic [4:0]           wb_rd;
    logic [`LSU_XLEN-1:0] wb_data;
    logic                 wb_we;
    logic                 wb_excp;

    logic [31:0]          lfsr_q;
    int                   errors;
    int                   tests_ok;
    int                   tests_bad;

    // One entry per pattern line
    mem_op_e              pat_op   [$];
    logic [`LSU_XLEN-1:0] pat_addr [$];
    logic [`LSU_XLEN-1:0] pat_data [$];
    logic [4:0]           pat_rd   [$];
    wb_t                  pat_exp  [$];

    lsu_top dut0 (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_op_i    (req_op),
        .req_addr_i  (req_addr),
        .req_data_i  (req_data),
        .req_rd_i    (req_rd),
        .wb_valid_o  (wb_valid),
        .wb_ready_i  (wb_ready),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data),
        .wb_we_o     (wb_we),
        .wb_excp_o   (wb_excp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic take_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_rd;
        logic [31:0] f_exp;
        logic [31:0] f_we;
        logic [31:0] f_excp;
        wb_t         exp;

        fd = $fopen("sim/lsu_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/lsu_patterns.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_op, f_addr, f_data, f_rd, f_exp, f_we, f_excp);
            if (n == 7) begin
                exp.rd   = f_rd[4:0];
                exp.data = f_exp;
                exp.we   = f_we[0];
                exp.excp = f_excp[0];
                pat_op.push_back(mem_op_e'(f_op[3:0]));
                pat_addr.push_back(f_addr);
                pat_data.push_back(f_data);
                pat_rd.push_back(f_rd[4:0]);
                pat_exp.push_back(exp);
            end else if (n > 0) begin
                $display("Pattern line could not be parsed: %s", line);
                errors++;
            end
        end
        $fclose(fd);
        if (pat_op.size() == 0) begin
            $display("Pattern file holds no operations");
            errors++;
        end
    endtask

    task automatic check_wb(input int idx, input wb_t got, input wb_t exp);
        if (got.rd !== exp.rd || got.data !== exp.data || got.we !== exp.we) begin
            $display("MISMATCH time %0t: test %0d rd %0d data %h we %b, expected %0d %h %b",
                     $time, idx, got.rd, got.data, got.we, exp.rd, exp.data, exp.we);
            errors++;
        end
    endtask

    task automatic check_excp(input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time %0t: test %0d exception flag %b, expected %b",
                     $time, idx, got, exp);
            errors++;
        end
    endtask

    initial begin : run_tests
        wb_t  got;
        int   n_pat;
        int   sent;
        int   done;
        int   idle;
        int   errs_before;
        logic req_fire;
        logic wb_fire;
        logic gap_a;
        logic gap_b;
        logic rdy_a;
        logic rdy_b;
        logic timed_out;

        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_op    = OP_LD_W;
        req_addr  = '0;
        req_data  = '0;
        req_rd    = '0;
        wb_ready  = 1'b0;
        lfsr_q    = 32'h690bd14c;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        sent      = 0;
        done      = 0;
        idle      = 0;
        req_fire  = 1'b0;
        timed_out = 1'b0;

        load_patterns();
        n_pat = pat_op.size();

        repeat (3) @(posedge clk);
        #10;
        arst_n = 1'b1;

        while (done < n_pat && !timed_out) begin
            if (req_fire) begin
                req_valid = 1'b0;
                sent++;
            end
            // About one cycle in four without a new request
            gap_a = take_bit();
            gap_b = take_bit();
            if (!req_valid && sent < n_pat && !(gap_a && gap_b)) begin
                req_valid = 1'b1;
                req_op    = pat_op[sent];
                req_addr  = pat_addr[sent];
                req_data  = pat_data[sent];
                req_rd    = pat_rd[sent];
            end
            rdy_a    = take_bit();
            rdy_b    = take_bit();
            wb_ready = rdy_a || rdy_b;

            // Handshakes judged mid-cycle ahead of the next edge
            @(negedge clk);
            req_fire = req_valid && req_ready;
            wb_fire  = wb_valid && wb_ready;
            if (wb_fire) begin
                got.rd      = wb_rd;
                got.data    = wb_data;
                got.we      = wb_we;
                got.excp    = wb_excp;
                errs_before = errors;
                check_wb(done, got, pat_exp[done]);
                check_excp(done, got.excp, pat_exp[done].excp);
                if (errors == errs_before) begin
                    tests_ok++;
                    $display("test %0d %s addr %h: ok", done, pat_op[done].name(),
                             pat_addr[done]);
                end else begin
                    tests_bad++;
                    $display("test %0d %s addr %h: error", done, pat_op[done].name(),
                             pat_addr[done]);
                end
                done++;
                idle = 0;
            end else begin
                idle++;
                if (idle >= TIMEOUT_CYCLES) begin
                    timed_out = 1'b1;
                end
            end
            @(posedge clk);
            #10;
        end

        if (timed_out) begin
            $display("Timeout: no writeback for %0d cycles, %0d of %0d results seen",
                     TIMEOUT_CYCLES, done, n_pat);
            errors++;
        end else begin
            req_valid = 1'b0;
            wb_ready  = 1'b1;
            for (int i = 0; i < DRAIN_CYCLES; i++) begin
                @(negedge clk);
                if (wb_valid) begin
                    $display("Extra writeback at time %0t after the last pattern", $time);
                    errors++;
                end
                @(posedge clk);
                #10;
            end
        end

        $display("%0d tests: %0d ok, %0d with errors, %0d errors in total",
                 n_pat, tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  lsu_pkg::mem_op_e      req_op_i,
    input  logic [`LSU_XLEN-1:0]  req_addr_i,
    input  logic [`LSU_XLEN-1:0]  req_data_i,
    input  logic [4:0]            req_rd_i,
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output logic [4:0]            wb_rd_o,
    output logic [`LSU_XLEN-1:0]  wb_data_o,
    output logic                  wb_we_o,
    output logic                  wb_excp_o
);
    import lsu_pkg::*;

    localparam int RAM_AW = $clog2(`LSU_RAM_WORDS);

    logic                 ram_en;
    logic                 ram_we;
    logic [3:0]           ram_sel;
    logic [RAM_AW-1:0]    ram_addr;
    logic [`LSU_XLEN-1:0] ram_wdata;
    logic [`LSU_XLEN-1:0] ram_rdata;
    wb_t                  wb;

    stage_if #(.T(mem_req_t)) issue_if ();
    stage_if #(.T(mem_req_t)) access_if ();

    mem_issue u_issue (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_rd_i    (req_rd_i),
        .out_o       (issue_if.producer)
    );

    stage_fifo #(
        .T     (mem_req_t),
        .DEPTH (`LSU_FIFO_DEPTH)
    ) u_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .in_i     (issue_if.consumer),
        .out_o    (access_if.producer)
    );

    mem_access u_access (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_i        (access_if.consumer),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ram_sel_o   (ram_sel),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_o        (wb)
    );

    data_ram u_ram (
        .clk_i   (clk_i),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .sel_i   (ram_sel),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    assign wb_rd_o   = wb.rd;
    assign wb_data_o = wb.data;
    assign wb_we_o   = wb.we;
    assign wb_excp_o = wb.excp;

endmodule

`default_nettype wire

/* hw/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module data_ram (
    input  logic                               clk_i,
    input  logic                               en_i,
    input  logic                               we_i,
    input  logic [3:0]                         sel_i,
    input  logic [$clog2(`LSU_RAM_WORDS)-1:0]  addr_i,
    input  logic [`LSU_XLEN-1:0]               wdata_i,
    output logic [`LSU_XLEN-1:0]               rdata_o
);
    logic [`LSU_XLEN-1:0] mem_q [`LSU_RAM_WORDS];

    // Byte lanes written under sel_i and reads registered
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel_i[i]) begin
                        mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                    end
                end
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mem_access.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module mem_access (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    stage_if.consumer                           in_i,
    output logic                                ram_en_o,
    output logic                                ram_we_o,
    output logic [3:0]                          ram_sel_o,
    output logic [$clog2(`LSU_RAM_WORDS)-1:0]   ram_addr_o,
    output logic [`LSU_XLEN-1:0]                ram_wdata_o,
    input  logic [`LSU_XLEN-1:0]                ram_rdata_i,
    output logic                                wb_valid_o,
    input  logic                                wb_ready_i,
    output lsu_pkg::wb_t                        wb_o
);
    import lsu_pkg::*;

    localparam int RAM_AW = $clog2(`LSU_RAM_WORDS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCESS,
        S_RESP,
        S_DONE
    } state_e;

    state_e               state_q;
    mem_req_t             req_q;
    logic                 ll_bit_q;
    logic                 sc_ok_q;
    wb_t                  wb_q;
    logic                 sc_ok;
    logic                 rd_write;
    logic [3:0]           byte_sel;
    logic [3:0]           half_sel;
    logic [7:0]           byte_lane;
    logic [15:0]          half_lane;
    logic [`LSU_XLEN-1:0] load_data;

    assign in_i.ready = state_q == S_IDLE;
    assign sc_ok      = (req_q.op == OP_SC) && ll_bit_q;
    assign byte_sel   = 4'b0001 << req_q.addr[1:0];
    assign half_sel   = req_q.addr[1] ? 4'b1100 : 4'b0011;
    assign ram_addr_o = req_q.addr[2 +: RAM_AW];

    // RAM request only for aligned ops in the access cycle
    always_comb begin
        ram_en_o    = 1'b0;
        ram_we_o    = 1'b0;
        ram_sel_o   = 4'b1111;
        ram_wdata_o = req_q.wdata;
        if (state_q == S_ACCESS && !req_q.misalign) begin
            case (req_q.op)
                OP_LD_B, OP_LD_BU: begin
                    ram_en_o  = 1'b1;
                    ram_sel_o = byte_sel;
                end
                OP_LD_H, OP_LD_HU: begin
                    ram_en_o  = 1'b1;
                    ram_sel_o = half_sel;
                end
                OP_LD_W, OP_LL: begin
                    ram_en_o = 1'b1;
                end
                OP_ST_B: begin
                    ram_en_o    = 1'b1;
                    ram_we_o    = 1'b1;
                    ram_sel_o   = byte_sel;
                    ram_wdata_o = {4{req_q.wdata[7:0]}};
                end
                OP_ST_H: begin
                    ram_en_o    = 1'b1;
                    ram_we_o    = 1'b1;
                    ram_sel_o   = half_sel;
                    ram_wdata_o = {2{req_q.wdata[15:0]}};
                end
                OP_ST_W: begin
                    ram_en_o = 1'b1;
                    ram_we_o = 1'b1;
                end
                OP_SC: begin
                    // Failed SC leaves memory alone
                    ram_en_o = sc_ok;
                    ram_we_o = sc_ok;
                end
                default: begin
                    ram_en_o = 1'b0;
                end
            endcase
        end
    end

    // Lane extraction and extension
    assign byte_lane = ram_rdata_i[{req_q.addr[1:0], 3'b000} +: 8];
    assign half_lane = req_q.addr[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];

    always_comb begin
        case (req_q.op)
            OP_LD_B:        load_data = {{(`LSU_XLEN-8){byte_lane[7]}}, byte_lane};
            OP_LD_BU:       load_data = {{(`LSU_XLEN-8){1'b0}}, byte_lane};
            OP_LD_H:        load_data = {{(`LSU_XLEN-16){half_lane[15]}}, half_lane};
            OP_LD_HU:       load_data = {{(`LSU_XLEN-16){1'b0}}, half_lane};
            OP_LD_W, OP_LL: load_data = ram_rdata_i;
            OP_SC:          load_data = {{(`LSU_XLEN-1){1'b0}}, sc_ok_q};
            default:        load_data = '0;
        endcase
    end

    // Plain stores write no register
    assign rd_write = !(req_q.op inside {OP_ST_B, OP_ST_H, OP_ST_W});

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= S_IDLE;
            ll_bit_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (in_i.valid) begin
                        state_q <= S_ACCESS;
                    end
                end
                S_ACCESS: begin
                    if (req_q.misalign) begin
                        state_q <= S_DONE;
                    end else begin
                        state_q <= S_RESP;
                        if (req_q.op == OP_LL) begin
                            ll_bit_q <= 1'b1;
                        end else if (sc_ok) begin
                            ll_bit_q <= 1'b0;
                        end
                    end
                end
                S_RESP: begin
                    state_q <= S_DONE;
                end
                S_DONE: begin
                    if (wb_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_i.valid && in_i.ready) begin
            req_q <= in_i.payload;
        end
        if (state_q == S_ACCESS) begin
            sc_ok_q <= sc_ok;
        end
        if (state_q == S_ACCESS && req_q.misalign) begin
            wb_q.rd   <= req_q.rd;
            wb_q.data <= '0;
            wb_q.we   <= 1'b0;
            wb_q.excp <= 1'b1;
        end else if (state_q == S_RESP) begin
            wb_q.rd   <= req_q.rd;
            wb_q.data <= load_data;
            wb_q.we   <= rd_write;
            wb_q.excp <= 1'b0;
        end
    end

    assign wb_valid_o = state_q == S_DONE;
    assign wb_o       = wb_q;

    // Result held until the writeback side takes it
    a_wb_hold: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
            wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o)
    );

endmodule

`default_nettype wire

/* hw/stage_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module stage_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `LSU_FIFO_DEPTH
) (
    input  logic      clk_i,
    input  logic      arst_n_i,
    stage_if.consumer in_i,
    stage_if.producer out_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             wr_en;
    logic             rd_en;

    assign in_i.ready    = count_q != CNT_W'(DEPTH);
    assign out_o.valid   = count_q != '0;
    assign out_o.payload = mem_q[rd_ptr_q];

    assign wr_en = in_i.valid && in_i.ready;
    assign rd_en = out_o.valid && out_o.ready;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= in_i.payload;
        end
    end

    // Pointers wrap at DEPTH since it need not be a power of two
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Full and not draining leaves count and write pointer alone
    a_no_write_full: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
            count_q == CNT_W'(DEPTH) && !rd_en |=> count_q == CNT_W'(DEPTH) && $stable(wr_ptr_q)
    );

    // Empty and not filling leaves count and read pointer alone
    a_no_read_empty: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
            count_q == '0 && !wr_en |=> count_q == '0 && $stable(rd_ptr_q)
    );

endmodule

`default_nettype wire

/* hw/mem_issue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module mem_issue (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  lsu_pkg::mem_op_e      req_op_i,
    input  logic [`LSU_XLEN-1:0]  req_addr_i,
    input  logic [`LSU_XLEN-1:0]  req_data_i,
    input  logic [4:0]            req_rd_i,
    stage_if.producer             out_o
);
    import lsu_pkg::*;

    logic     out_valid_q;
    mem_req_t out_req_q;
    logic     misalign;
    logic     accept;

    // Alignment rule per access size
    always_comb begin
        case (req_op_i)
            OP_LD_H, OP_LD_HU, OP_ST_H: begin
                misalign = req_addr_i[0];
            end
            OP_LD_W, OP_ST_W, OP_LL, OP_SC: begin
                misalign = |req_addr_i[1:0];
            end
            default: begin
                misalign = 1'b0;
            end
        endcase
    end

    // Register empty or draining this cycle
    assign req_ready_o = !out_valid_q || out_o.ready;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            out_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_req_q.op       <= req_op_i;
            out_req_q.addr     <= req_addr_i;
            out_req_q.wdata    <= req_data_i;
            out_req_q.rd       <= req_rd_i;
            out_req_q.misalign <= misalign;
        end
    end

    assign out_o.valid   = out_valid_q;
    assign out_o.payload = out_req_q;

    // Stalled request must not change under the FIFO
    property p_hold_payload;
        @(posedge clk_i) disable iff (!arst_n_i)
            out_o.valid && !out_o.ready |=> out_o.valid && $stable(out_o.payload);
    endproperty

    a_hold_payload: assert property (p_hold_payload);

endmodule

`default_nettype wire

/* hw/stage_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface stage_if #(
    parameter type T = logic
);
    logic valid;
    logic ready;
    T     payload;

    // Payload held stable from valid until the handshake
    modport producer (
        output valid,
        output payload,
        input  ready
    );

    modport consumer (
        input  valid,
        input  payload,
        output ready
    );
endinterface

`default_nettype wire

/* hw/lsu_pkg.sv */
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

    // Memory operations handled by the slice
    typedef enum logic [3:0] {
        OP_LD_B  = 4'h0,
        OP_LD_BU = 4'h1,
        OP_LD_H  = 4'h2,
        OP_LD_HU = 4'h3,
        OP_LD_W  = 4'h4,
        OP_ST_B  = 4'h5,
        OP_ST_H  = 4'h6,
        OP_ST_W  = 4'h7,
        OP_LL    = 4'h8,
        OP_SC    = 4'h9
    } mem_op_e;

    // Request travelling from issue to access
    typedef struct packed {
        mem_op_e               op;
        logic [`LSU_XLEN-1:0]  addr;
        logic [`LSU_XLEN-1:0]  wdata;
        logic [4:0]            rd;
        logic                  misalign;
    } mem_req_t;

    // Writeback result
    typedef struct packed {
        logic [4:0]            rd;
        logic [`LSU_XLEN-1:0]  data;
        logic                  we;
        logic                  excp;
    } wb_t;

endpackage

`default_nettype wire

/* hw/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width of one word
`define LSU_XLEN 32

// Entries in the buffer between issue and access
`define LSU_FIFO_DEPTH 4

// Data RAM depth in words
`define LSU_RAM_WORDS 64

`endif
